// File: build.f
+incdir+test
source/im2col_pkg.sv
source/im2col_regs.sv
source/im2col_param_gen.sv
source/im2col_txn_fifo.sv
source/im2col_dma_loader.sv
source/im2col_top.sv
test/tb_im2col.sv

// File: Bender.yml
package:
  name: im2col

sources:
  - files:
      - source/im2col_pkg.sv
      - source/im2col_regs.sv
      - source/im2col_param_gen.sv
      - source/im2col_txn_fifo.sv
      - source/im2col_dma_loader.sv
      - source/im2col_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_im2col.sv

// File: test/tb_im2col_ref.svh
// im2col reference model building the expected DMA register write list of one run
`ifndef TB_IM2COL_REF_SVH
`define TB_IM2COL_REF_SVH

function automatic void expect_write(input logic [31:0] off, input logic [31:0] data);
  exp_q.push_back({DmaBase + off, data});
endfunction

function automatic int clamp_zero(input int value);
  return (value > 0) ? value : 0;
endfunction

function automatic void build_expected(input im2col_cfg_t cfg);
  int          iw;
  int          ih;
  int          fw;
  int          fh;
  int          pt;
  int          pb;
  int          pl;
  int          pr;
  int          npw;
  int          nph;
  int          zl;
  int          zr;
  int          zt;
  int          zb;
  int          sd1;
  int          sd2;
  int          idx;
  int          c;
  int          h;
  int          w;
  logic [31:0] dst;
  iw  = int'(cfg.iw);
  ih  = int'(cfg.ih);
  fw  = int'(cfg.fw);
  fh  = int'(cfg.fh);
  pt  = int'(cfg.pad_top);
  pb  = int'(cfg.pad_bottom);
  pl  = int'(cfg.pad_left);
  pr  = int'(cfg.pad_right);
  npw = iw + pl + pr - fw + 1;  // Patches per row
  nph = ih + pt + pb - fh + 1;
  dst = cfg.dst_ptr;
  expect_write(DmaDimOff, 32'd1);  // Once per run
  for (c = 0; c < int'(cfg.num_ch); c++) begin
    for (h = 0; h < fh; h++) begin
      for (w = 0; w < fw; w++) begin
        zl  = clamp_zero(pl - w);
        zr  = clamp_zero(pr - (fw - 1 - w));
        zt  = clamp_zero(pt - h);
        zb  = clamp_zero(pb - (fh - 1 - h));
        sd1 = npw - zl - zr;
        sd2 = nph - zt - zb;
        idx = (c * ih + h - pt + zt) * iw + (w - pl + zl);
        // Byte values, four bytes per element
        expect_write(DmaSrcPtrOff, cfg.src_ptr + 32'(4 * idx));
        expect_write(DmaDstPtrOff, dst);
        expect_write(DmaIncSrcD1Off, 32'd4);
        expect_write(DmaIncSrcD2Off, 32'(4 * (iw - sd1 + 1)));
        expect_write(DmaIncDstD1Off, 32'd4);
        expect_write(DmaSizeD2Off, 32'(4 * sd2));
        expect_write(DmaTopPadOff, 32'(4 * zt));
        expect_write(DmaBottomPadOff, 32'(4 * zb));
        expect_write(DmaLeftPadOff, 32'(4 * zl));
        expect_write(DmaRightPadOff, 32'(4 * zr));
        expect_write(DmaSizeD1Off, 32'(4 * sd1));  // Starts the DMA
        dst = dst + 32'(4 * npw * nph);
      end
    end
  end
endfunction

`endif

// File: test/tb_im2col.sv
// im2col controller testbench with APB driver, DMA responder model and write list compare
`timescale 1ns/1ps

module tb_im2col import im2col_pkg::*; ();

  logic        clk_i;
  logic        rst_ni;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  dma_req_t    dma_req;
  dma_rsp_t    dma_rsp;
  logic        dma_done;
  logic        irq;
  integer      seed = 32'h03135abc;
  int          err_cnt = 0;
  int          check_cnt = 0;
  int          cycle_cnt = 0;
  int          timeout_limit = 0;
  logic        ack_seen = 1'b0;  // Write completed in the previous cycle
  logic [63:0] exp_q[$];  // Expected {addr, wdata}
  logic [63:0] log_q[$];  // Completed writes

  `include "tb_im2col_ref.svh"

  im2col_top u_im2col_top (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .apb_req_i  (apb_req),
    .apb_rsp_o  (apb_rsp),
    .dma_req_o  (dma_req),
    .dma_rsp_i  (dma_rsp),
    .dma_done_i (dma_done),
    .irq_o      (irq)
  );

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;  // 40 ns period

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp_val);
    check_cnt++;
    if (got !== exp_val) begin
      err_cnt++;
      $display("ERR %s got %h expected %h at %0t", name, got, exp_val, $time);
    end
  endtask

  function automatic int count_writes(input im2col_cfg_t cfg);
    return 1 + 11 * int'(cfg.num_ch) * int'(cfg.fh) * int'(cfg.fw);
  endfunction

  task automatic apb_access(input logic write, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    @(posedge clk_i);
    #2;
    apb_req.psel    = 1'b1;  // Setup phase
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(posedge clk_i);
    #2;
    apb_req.penable = 1'b1;
    @(negedge clk_i);
    while (!apb_rsp.pready) begin
      @(negedge clk_i);
    end
    rdata = apb_rsp.prdata;  // Stable mid-cycle
    check_value("apb_rsp_o.pslverr", 32'(apb_rsp.pslverr), 32'h0);
    @(posedge clk_i);
    #2;
    apb_req = '0;
  endtask

  task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    apb_access(1'b1, addr, data, unused);
  endtask

  task automatic apb_read(input logic [31:0] addr, output logic [31:0] data);
    apb_access(1'b0, addr, 32'h0, data);
  endtask

  task automatic write_and_readback(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] rdata;
    apb_write(addr, data);
    apb_read(addr, rdata);
    check_value("apb_rsp_o.prdata", rdata, data);
  endtask

  task automatic program_config(input im2col_cfg_t cfg, input logic int_en);
    apb_write(RegSrcPtr, cfg.src_ptr);
    apb_write(RegDstPtr, cfg.dst_ptr);
    apb_write(RegIw, 32'(cfg.iw));
    apb_write(RegIh, 32'(cfg.ih));
    apb_write(RegFw, 32'(cfg.fw));
    apb_write(RegFh, 32'(cfg.fh));
    apb_write(RegPad, {cfg.pad_top, cfg.pad_bottom, cfg.pad_left, cfg.pad_right});
    apb_write(RegIntEn, 32'(int_en));
  endtask

  // Program, start, wait for the end of the run and check status and flag
  task automatic run_and_check(input im2col_cfg_t cfg, input logic int_en);
    logic [31:0] rdata;
    build_expected(cfg);
    program_config(cfg, int_en);
    apb_write(RegNumCh, 32'(cfg.num_ch));
    apb_read(RegNumCh, rdata);
    check_value("apb_rsp_o.prdata", rdata, 32'(cfg.num_ch));
    if (int_en) begin
      @(negedge clk_i);
      while (irq !== 1'b1) begin
        @(negedge clk_i);
      end
      apb_read(RegStatus, rdata);
      check_value("apb_rsp_o.prdata", rdata, 32'h1);
      apb_read(RegIfr, rdata);
      check_value("apb_rsp_o.prdata", rdata, 32'h1);
      check_value("irq_o", 32'(irq), 32'h0);  // Cleared by the read
    end else begin
      rdata = 32'h0;
      while (rdata[0] !== 1'b1) begin
        apb_read(RegStatus, rdata);
      end
      check_value("irq_o", 32'(irq), 32'h0);
    end
    if (exp_q.size() != 0) begin
      err_cnt++;
      $display("Run ended with %0d expected DMA writes missing", exp_q.size());
      exp_q.delete();
    end
  endtask

  // DMA responder with random write acknowledge and done delays
  initial begin : dma_responder
    int   lat;
    int   done_cnt;
    logic busy;
    dma_rsp  = '0;
    dma_done = 1'b0;
    lat      = 0;
    done_cnt = 0;
    busy     = 1'b0;
    forever begin
      @(posedge clk_i);
      #2;
      dma_rsp.rvalid = 1'b0;
      dma_done       = 1'b0;
      if (done_cnt > 0) begin
        done_cnt = done_cnt - 1;
        if (done_cnt == 0) begin
          dma_done = 1'b1;
        end
      end
      if (dma_req.req && !busy) begin
        busy = 1'b1;
        lat  = $unsigned($random(seed)) % 4;  // 0 to 3 wait cycles
      end
      if (busy) begin
        if (lat == 0) begin
          dma_rsp.rvalid = 1'b1;
          busy           = 1'b0;
          if (dma_req.addr == DmaBase + DmaSizeD1Off) begin
            done_cnt = 5 + $unsigned($random(seed)) % 16;
          end
        end else begin
          lat = lat - 1;
        end
      end
    end
  end

  always @(negedge clk_i) begin
    if (rst_ni && dma_req.req && ack_seen) begin
      err_cnt++;
      $display("DMA request stayed high in the cycle after a completed write at %0t", $time);
    end
    ack_seen = rst_ni && dma_req.req && dma_rsp.rvalid;
    if (ack_seen) begin
      log_q.push_back({dma_req.addr, dma_req.wdata});  // Write completes at next edge
    end
  end

  initial begin : compare_writes
    logic [63:0] got_w;
    logic [63:0] exp_w;
    forever begin
      @(posedge clk_i);
      while (log_q.size() > 0) begin
        got_w = log_q.pop_front();
        if (exp_q.size() == 0) begin
          err_cnt++;
          $display("Unexpected DMA write to address %h with data %h", got_w[63:32], got_w[31:0]);
        end else begin
          exp_w = exp_q.pop_front();
          check_value("dma_req_o.addr", got_w[63:32], exp_w[63:32]);
          check_value("dma_req_o.wdata", got_w[31:0], exp_w[31:0]);
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= timeout_limit) begin
      $display("Timeout after %0d cycles, the runs did not complete", cycle_cnt);
      $display("Errors found");
      $finish;
    end
  end

  initial begin : main
    im2col_cfg_t cfg_a;
    im2col_cfg_t cfg_b;
    logic [31:0] rdata;
    cfg_a            = '0;  // No padding, one channel
    cfg_a.src_ptr    = 32'h1000_0000;
    cfg_a.dst_ptr    = 32'h2000_0000;
    cfg_a.iw         = 16'd4;
    cfg_a.ih         = 16'd4;
    cfg_a.fw         = 16'd2;
    cfg_a.fh         = 16'd2;
    cfg_a.num_ch     = 16'd1;
    cfg_b            = '0;  // All pads set, two channels
    cfg_b.src_ptr    = 32'h1001_0000;
    cfg_b.dst_ptr    = 32'h2004_0000;
    cfg_b.iw         = 16'd5;
    cfg_b.ih         = 16'd4;
    cfg_b.fw         = 16'd3;
    cfg_b.fh         = 16'd3;
    cfg_b.num_ch     = 16'd2;
    cfg_b.pad_top    = 8'd1;
    cfg_b.pad_bottom = 8'd2;
    cfg_b.pad_left   = 8'd2;
    cfg_b.pad_right  = 8'd1;
    timeout_limit = (count_writes(cfg_a) + 2 * count_writes(cfg_b)) * 40 + 2000;
    apb_req = '0;
    rst_ni  = 1'b0;
    repeat (4) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    apb_read(RegStatus, rdata);
    check_value("apb_rsp_o.prdata", rdata, 32'h0);
    write_and_readback(RegSrcPtr, 32'hCAFE_0040);
    write_and_readback(RegDstPtr, 32'h0BAD_F00C);
    write_and_readback(RegIw, 32'h0000_1234);
    write_and_readback(RegIh, 32'h0000_00A5);
    write_and_readback(RegFw, 32'h0000_0007);
    write_and_readback(RegFh, 32'h0000_0B02);
    write_and_readback(RegPad, 32'h0102_0304);
    write_and_readback(RegIntEn, 32'h0000_0001);

    run_and_check(cfg_a, 1'b0);
    run_and_check(cfg_b, 1'b1);
    run_and_check(cfg_b, 1'b1);  // Dimensionality and dst restart

    repeat (10) @(posedge clk_i);
    $display("Checks %0d, errors %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: source/im2col_top.sv
// im2col controller top level joining registers, generator, queue and DMA loader
`timescale 1ns/1ps

module im2col_top import im2col_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  apb_req_t apb_req_i,
  output apb_rsp_t apb_rsp_o,
  output dma_req_t dma_req_o,
  input  dma_rsp_t dma_rsp_i,
  input  logic     dma_done_i,
  output logic     irq_o
);

  im2col_cfg_t cfg;
  logic        start;
  logic        gen_done;
  logic        run_done;
  im2col_txn_t gen_txn;
  logic        gen_valid;
  logic        gen_ready;
  im2col_txn_t fifo_txn;
  logic        fifo_valid;
  logic        fifo_ready;

  im2col_regs u_regs (
    .clk_i,
    .rst_ni,
    .apb_req_i,
    .apb_rsp_o,
    .run_done_i (run_done),
    .cfg_o      (cfg),
    .start_o    (start),
    .irq_o
  );

  im2col_param_gen u_param_gen (
    .clk_i,
    .rst_ni,
    .cfg_i      (cfg),
    .start_i    (start),
    .txn_o      (gen_txn),
    .valid_o    (gen_valid),
    .ready_i    (gen_ready),
    .gen_done_o (gen_done)
  );

  im2col_txn_fifo #(
    .dtype (im2col_txn_t),
    .Depth (FifoDepth)
  ) u_txn_fifo (
    .clk_i,
    .rst_ni,
    .data_i  (gen_txn),
    .valid_i (gen_valid),
    .ready_o (gen_ready),
    .data_o  (fifo_txn),
    .valid_o (fifo_valid),
    .ready_i (fifo_ready)
  );

  im2col_dma_loader u_dma_loader (
    .clk_i,
    .rst_ni,
    .txn_i      (fifo_txn),
    .valid_i    (fifo_valid),
    .ready_o    (fifo_ready),
    .start_i    (start),
    .gen_done_i (gen_done),
    .dma_req_o,
    .dma_rsp_i,
    .dma_done_i,
    .run_done_o (run_done)
  );

endmodule

// File: source/im2col_dma_loader.sv
// DMA loader writing each transaction into the DMA channel registers and tracking run end
`timescale 1ns/1ps

module im2col_dma_loader import im2col_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  im2col_txn_t txn_i,
  input  logic        valid_i,
  output logic        ready_o,
  input  logic        start_i,
  input  logic        gen_done_i,
  output dma_req_t    dma_req_o,
  input  dma_rsp_t    dma_rsp_i,
  input  logic        dma_done_i,
  output logic        run_done_o
);

  // Register writes in bus order
  typedef enum logic [3:0] {
    WrDim, WrSrc, WrDst, WrIncSrcD1, WrIncSrcD2, WrIncDstD1, WrSizeD2,
    WrTopPad, WrBottomPad, WrLeftPad, WrRightPad, WrSizeD1
  } step_e;

  typedef enum logic [1:0] {Idle, Request, Gap, WaitDone} state_e;

  state_e               state_q;
  step_e                step_q;
  logic                 first_q;
  logic                 gen_seen_q;
  logic                 write_ack;
  logic [AddrWidth-1:0] offset;
  logic [DataWidth-1:0] wdata;

  assign write_ack = (state_q == Request) && dma_rsp_i.rvalid;

  always_comb begin
    case (step_q)
      WrDim:       offset = DmaDimOff;
      WrSrc:       offset = DmaSrcPtrOff;
      WrDst:       offset = DmaDstPtrOff;
      WrIncSrcD1:  offset = DmaIncSrcD1Off;
      WrIncSrcD2:  offset = DmaIncSrcD2Off;
      WrIncDstD1:  offset = DmaIncDstD1Off;
      WrSizeD2:    offset = DmaSizeD2Off;
      WrTopPad:    offset = DmaTopPadOff;
      WrBottomPad: offset = DmaBottomPadOff;
      WrLeftPad:   offset = DmaLeftPadOff;
      WrRightPad:  offset = DmaRightPadOff;
      default:     offset = DmaSizeD1Off;
    endcase
    case (step_q)
      WrDim:       wdata = DataWidth'(1);  // 2D transfers
      WrSrc:       wdata = txn_i.src_ptr;
      WrDst:       wdata = txn_i.dst_ptr;
      WrIncSrcD2:  wdata = txn_i.inc_src_d2 * ElemBytes;
      WrSizeD2:    wdata = DataWidth'(txn_i.size_d2) * ElemBytes;
      WrTopPad:    wdata = DataWidth'(txn_i.pad_top) * ElemBytes;
      WrBottomPad: wdata = DataWidth'(txn_i.pad_bottom) * ElemBytes;
      WrLeftPad:   wdata = DataWidth'(txn_i.pad_left) * ElemBytes;
      WrRightPad:  wdata = DataWidth'(txn_i.pad_right) * ElemBytes;
      WrSizeD1:    wdata = DataWidth'(txn_i.size_d1) * ElemBytes;
      default:     wdata = ElemBytes;  // Unit increments in d1
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= Idle;
      step_q     <= WrSrc;
      first_q    <= 1'b0;
      gen_seen_q <= 1'b0;
    end else begin
      if (start_i) begin
        first_q <= 1'b1;  // Dimensionality once per run
      end else if (write_ack && step_q == WrDim) begin
        first_q <= 1'b0;
      end
      if (start_i || run_done_o) begin
        gen_seen_q <= 1'b0;
      end else if (gen_done_i) begin
        gen_seen_q <= 1'b1;
      end
      case (state_q)
        Idle: begin
          if (valid_i) begin
            state_q <= Request;
            step_q  <= first_q ? WrDim : WrSrc;
          end
        end
        Request: begin
          if (write_ack) begin
            if (step_q == WrSizeD1) begin
              state_q <= WaitDone;
            end else begin
              state_q <= Gap;
              step_q  <= step_e'(step_q + 1'b1);
            end
          end
        end
        Gap:      state_q <= Request;  // req low between writes
        WaitDone: state_q <= dma_done_i ? Idle : WaitDone;
        default:  state_q <= Idle;
      endcase
    end
  end

  assign dma_req_o.req   = (state_q == Request);
  assign dma_req_o.addr  = DmaBase + offset;
  assign dma_req_o.wdata = wdata;

  assign ready_o    = (state_q == WaitDone) && dma_done_i;  // Pop once the DMA is finished
  assign run_done_o = gen_seen_q && (state_q == Idle) && !valid_i;

endmodule

// File: source/im2col_txn_fifo.sv
// Fall-through circular buffer FIFO with a generic payload type
`timescale 1ns/1ps

module im2col_txn_fifo #(
  parameter type         dtype = logic,
  parameter int unsigned Depth = 2
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  dtype data_i,
  input  logic valid_i,
  output logic ready_o,
  output dtype data_o,
  output logic valid_o,
  input  logic ready_i
);

  dtype                         mem_q [Depth];
  logic [$clog2(Depth)-1:0]     wr_ptr_q;
  logic [$clog2(Depth)-1:0]     rd_ptr_q;
  logic [$clog2(Depth+1)-1:0]   count_q;
  logic                         push;
  logic                         pop;

  assign push    = valid_i && ready_o;
  assign pop     = valid_o && ready_i;
  assign ready_o = (count_q != Depth);
  assign valid_o = (count_q != 0);
  assign data_o  = mem_q[rd_ptr_q];  // Head entry visible without a pop

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == Depth - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == Depth - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// File: source/im2col_param_gen.sv
// im2col parameter generator walking channel and filter offsets into DMA transactions
`timescale 1ns/1ps

module im2col_param_gen import im2col_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  im2col_cfg_t cfg_i,
  input  logic        start_i,
  output im2col_txn_t txn_o,
  output logic        valid_o,
  input  logic        ready_i,
  output logic        gen_done_o
);

  typedef enum logic [2:0] {
    Idle,
    Offsets,
    Pads,
    Sizes,
    Pointers,
    Push,
    Advance
  } state_e;

  state_e               state_q;
  logic [DimWidth-1:0]  c_q;
  logic [DimWidth-1:0]  h_q;
  logic [DimWidth-1:0]  w_q;
  logic [DimWidth-1:0]  npw_q;
  logic [DimWidth-1:0]  nph_q;
  logic [DimWidth-1:0]  fw_m_w_q;
  logic [DimWidth-1:0]  fh_m_h_q;
  logic [DataWidth-1:0] dst_q;
  logic [DataWidth-1:0] row_q;
  logic [DataWidth-1:0] col_q;
  logic                 last_step;
  im2col_txn_t          txn_q;

  assign last_step = (w_q == cfg_i.fw - 1'b1) && (h_q == cfg_i.fh - 1'b1) &&
                     (c_q == cfg_i.num_ch - 1'b1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
      c_q     <= '0;
      h_q     <= '0;
      w_q     <= '0;
      npw_q   <= '0;
      nph_q   <= '0;
      dst_q   <= '0;
    end else begin
      case (state_q)
        Idle: begin
          if (start_i) begin
            state_q <= Offsets;
            c_q     <= '0;
            h_q     <= '0;
            w_q     <= '0;
            dst_q   <= cfg_i.dst_ptr;
            npw_q   <= cfg_i.iw + DimWidth'(cfg_i.pad_left) + DimWidth'(cfg_i.pad_right) -
                       cfg_i.fw + 1'b1;
            nph_q   <= cfg_i.ih + DimWidth'(cfg_i.pad_top) + DimWidth'(cfg_i.pad_bottom) -
                       cfg_i.fh + 1'b1;
          end
        end
        Offsets:  state_q <= Pads;
        Pads:     state_q <= Sizes;
        Sizes:    state_q <= Pointers;
        Pointers: state_q <= Push;
        Push: begin
          if (ready_i) begin
            state_q <= Advance;  // Held while queue is full
          end
        end
        Advance: begin
          dst_q   <= dst_q + ElemBytes * DataWidth'(npw_q) * DataWidth'(nph_q);
          state_q <= last_step ? Idle : Offsets;
          // w innermost, then h, then c
          if (w_q == cfg_i.fw - 1'b1) begin
            w_q <= '0;
            if (h_q == cfg_i.fh - 1'b1) begin
              h_q <= '0;
              c_q <= c_q + 1'b1;
            end else begin
              h_q <= h_q + 1'b1;
            end
          end else begin
            w_q <= w_q + 1'b1;
          end
        end
        default: state_q <= Idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    case (state_q)
      Offsets: begin
        fw_m_w_q <= cfg_i.fw - 1'b1 - w_q;
        fh_m_h_q <= cfg_i.fh - 1'b1 - h_q;
      end
      Pads: begin  // Zeros that fall outside the image
        txn_q.pad_left   <= (w_q < DimWidth'(cfg_i.pad_left)) ?
                            cfg_i.pad_left - PadWidth'(w_q) : '0;
        txn_q.pad_right  <= (fw_m_w_q < DimWidth'(cfg_i.pad_right)) ?
                            cfg_i.pad_right - PadWidth'(fw_m_w_q) : '0;
        txn_q.pad_top    <= (h_q < DimWidth'(cfg_i.pad_top)) ?
                            cfg_i.pad_top - PadWidth'(h_q) : '0;
        txn_q.pad_bottom <= (fh_m_h_q < DimWidth'(cfg_i.pad_bottom)) ?
                            cfg_i.pad_bottom - PadWidth'(fh_m_h_q) : '0;
      end
      Sizes: begin
        txn_q.size_d1 <= npw_q - DimWidth'(txn_q.pad_left) - DimWidth'(txn_q.pad_right);
        txn_q.size_d2 <= nph_q - DimWidth'(txn_q.pad_top) - DimWidth'(txn_q.pad_bottom);
        row_q <= DataWidth'(c_q) * DataWidth'(cfg_i.ih) + DataWidth'(h_q) +
                 DataWidth'(txn_q.pad_top) - DataWidth'(cfg_i.pad_top);
        col_q <= DataWidth'(w_q) + DataWidth'(txn_q.pad_left) - DataWidth'(cfg_i.pad_left);
      end
      Pointers: begin
        txn_q.src_ptr    <= cfg_i.src_ptr + ElemBytes * (row_q * DataWidth'(cfg_i.iw) + col_q);
        txn_q.dst_ptr    <= dst_q;
        txn_q.inc_src_d2 <= DataWidth'(cfg_i.iw) - DataWidth'(txn_q.size_d1) + 1'b1;
      end
      default: ;
    endcase
  end

  assign txn_o      = txn_q;
  assign valid_o    = (state_q == Push);
  assign gen_done_o = (state_q == Advance) && last_step;  // After the last push

endmodule

// File: source/im2col_regs.sv
// im2col APB register block with configuration, start, done status and interrupt flag
`timescale 1ns/1ps

module im2col_regs import im2col_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  apb_req_t    apb_req_i,
  output apb_rsp_t    apb_rsp_o,
  input  logic        run_done_i,
  output im2col_cfg_t cfg_o,
  output logic        start_o,
  output logic        irq_o
);

  im2col_cfg_t          cfg_q;
  logic                 start_q;
  logic                 done_q;
  logic                 ifr_q;
  logic                 int_en_q;
  logic                 wr_en;
  logic                 rd_en;
  logic [DataWidth-1:0] rdata;

  assign wr_en = apb_req_i.psel && apb_req_i.penable && apb_req_i.pwrite;  // Access phase
  assign rd_en = apb_req_i.psel && apb_req_i.penable && !apb_req_i.pwrite;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q    <= '0;
      start_q  <= 1'b0;
      int_en_q <= 1'b0;
    end else begin
      start_q <= 1'b0;
      if (wr_en) begin
        case (apb_req_i.paddr)
          RegSrcPtr: cfg_q.src_ptr <= apb_req_i.pwdata;
          RegDstPtr: cfg_q.dst_ptr <= apb_req_i.pwdata;
          RegIw:     cfg_q.iw <= apb_req_i.pwdata[DimWidth-1:0];
          RegIh:     cfg_q.ih <= apb_req_i.pwdata[DimWidth-1:0];
          RegFw:     cfg_q.fw <= apb_req_i.pwdata[DimWidth-1:0];
          RegFh:     cfg_q.fh <= apb_req_i.pwdata[DimWidth-1:0];
          RegPad: begin
            cfg_q.pad_top    <= apb_req_i.pwdata[31:24];
            cfg_q.pad_bottom <= apb_req_i.pwdata[23:16];
            cfg_q.pad_left   <= apb_req_i.pwdata[15:8];
            cfg_q.pad_right  <= apb_req_i.pwdata[7:0];
          end
          RegNumCh: begin
            cfg_q.num_ch <= apb_req_i.pwdata[DimWidth-1:0];
            start_q      <= 1'b1;  // Run starts next cycle
          end
          RegIntEn:  int_en_q <= apb_req_i.pwdata[0];
          default: ;
        endcase
      end
    end
  end

  // Done status and interrupt flag
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_q <= 1'b0;
      ifr_q  <= 1'b0;
    end else begin
      if (start_q) begin
        done_q <= 1'b0;
      end else if (run_done_i) begin
        done_q <= 1'b1;
      end
      if (run_done_i && int_en_q) begin
        ifr_q <= 1'b1;
      end else if (rd_en && apb_req_i.paddr == RegIfr) begin
        ifr_q <= 1'b0;  // Clear on read
      end
    end
  end

  always_comb begin
    case (apb_req_i.paddr)
      RegSrcPtr: rdata = cfg_q.src_ptr;
      RegDstPtr: rdata = cfg_q.dst_ptr;
      RegIw:     rdata = DataWidth'(cfg_q.iw);
      RegIh:     rdata = DataWidth'(cfg_q.ih);
      RegFw:     rdata = DataWidth'(cfg_q.fw);
      RegFh:     rdata = DataWidth'(cfg_q.fh);
      RegPad:    rdata = {cfg_q.pad_top, cfg_q.pad_bottom, cfg_q.pad_left, cfg_q.pad_right};
      RegNumCh:  rdata = DataWidth'(cfg_q.num_ch);
      RegStatus: rdata = DataWidth'(done_q);
      RegIfr:    rdata = DataWidth'(ifr_q);
      RegIntEn:  rdata = DataWidth'(int_en_q);
      default:   rdata = '0;
    endcase
  end

  assign apb_rsp_o.prdata  = rdata;
  assign apb_rsp_o.pready  = 1'b1;  // No wait states
  assign apb_rsp_o.pslverr = 1'b0;

  assign cfg_o   = cfg_q;
  assign start_o = start_q;
  assign irq_o   = ifr_q;

endmodule

// File: source/im2col_pkg.sv
// im2col controller shared types, register map and DMA register offsets
package im2col_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned DimWidth  = 16;
  localparam int unsigned PadWidth  = 8;
  localparam int unsigned FifoDepth = 4;

  localparam logic [DataWidth-1:0] ElemBytes = 32'd4;  // 32-bit words only

  localparam logic [AddrWidth-1:0] DmaBase = 32'h0003_0000;

  // DMA channel register offsets
  localparam logic [AddrWidth-1:0] DmaSrcPtrOff    = 32'h00;
  localparam logic [AddrWidth-1:0] DmaDstPtrOff    = 32'h04;
  localparam logic [AddrWidth-1:0] DmaSizeD1Off    = 32'h0C;  // Starts the transfer
  localparam logic [AddrWidth-1:0] DmaSizeD2Off    = 32'h10;
  localparam logic [AddrWidth-1:0] DmaIncSrcD1Off  = 32'h18;
  localparam logic [AddrWidth-1:0] DmaIncSrcD2Off  = 32'h1C;
  localparam logic [AddrWidth-1:0] DmaIncDstD1Off  = 32'h20;
  localparam logic [AddrWidth-1:0] DmaDimOff       = 32'h34;
  localparam logic [AddrWidth-1:0] DmaTopPadOff    = 32'h3C;
  localparam logic [AddrWidth-1:0] DmaBottomPadOff = 32'h40;
  localparam logic [AddrWidth-1:0] DmaRightPadOff  = 32'h44;
  localparam logic [AddrWidth-1:0] DmaLeftPadOff   = 32'h48;

  // APB register map
  localparam logic [AddrWidth-1:0] RegSrcPtr = 32'h00;
  localparam logic [AddrWidth-1:0] RegDstPtr = 32'h04;
  localparam logic [AddrWidth-1:0] RegIw     = 32'h08;
  localparam logic [AddrWidth-1:0] RegIh     = 32'h0C;
  localparam logic [AddrWidth-1:0] RegFw     = 32'h10;
  localparam logic [AddrWidth-1:0] RegFh     = 32'h14;
  localparam logic [AddrWidth-1:0] RegPad    = 32'h18;  // Top, bottom, left, right
  localparam logic [AddrWidth-1:0] RegNumCh  = 32'h20;  // Write starts a run
  localparam logic [AddrWidth-1:0] RegStatus = 32'h24;
  localparam logic [AddrWidth-1:0] RegIfr    = 32'h28;
  localparam logic [AddrWidth-1:0] RegIntEn  = 32'h2C;

  typedef struct packed {
    logic [DataWidth-1:0] src_ptr;
    logic [DataWidth-1:0] dst_ptr;
    logic [DimWidth-1:0]  iw;
    logic [DimWidth-1:0]  ih;
    logic [DimWidth-1:0]  fw;
    logic [DimWidth-1:0]  fh;
    logic [DimWidth-1:0]  num_ch;
    logic [PadWidth-1:0]  pad_top;
    logic [PadWidth-1:0]  pad_bottom;
    logic [PadWidth-1:0]  pad_left;
    logic [PadWidth-1:0]  pad_right;
  } im2col_cfg_t;

  // One DMA transaction, pads counted in elements
  typedef struct packed {
    logic [DataWidth-1:0] src_ptr;
    logic [DataWidth-1:0] dst_ptr;
    logic [DataWidth-1:0] inc_src_d2;
    logic [DimWidth-1:0]  size_d1;
    logic [DimWidth-1:0]  size_d2;
    logic [PadWidth-1:0]  pad_top;
    logic [PadWidth-1:0]  pad_bottom;
    logic [PadWidth-1:0]  pad_left;
    logic [PadWidth-1:0]  pad_right;
  } im2col_txn_t;

  typedef struct packed {
    logic                 req;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
  } dma_req_t;

  typedef struct packed {
    logic rvalid;
  } dma_rsp_t;

  typedef struct packed {
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [AddrWidth-1:0] paddr;
    logic [DataWidth-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [DataWidth-1:0] prdata;
    logic                 pready;
    logic                 pslverr;
  } apb_rsp_t;

endpackage
